/* logic/videoPkg.sv */
`default_nettype none

package videoPkg;
	localparam int coordWidth = 10;

	typedef logic [coordWidth-1:0] coord;

	typedef struct packed {
		coord column;
		coord row;
	} screenPos;

	// The floor line with the gap. The ball and the scene both depend on it.
	function automatic int floorRowOf(int screenHeight);
		return screenHeight - screenHeight / 6;
	endfunction

	function automatic int springLeftOf(int screenWidth);
		return screenWidth - screenWidth / 8;
	endfunction

	function automatic int springTopOf(int screenHeight);
		return floorRowOf(screenHeight) - screenHeight / 16;
	endfunction
endpackage

`default_nettype wire

/* logic/pinballPkg.sv */
`default_nettype none

package pinballPkg;
	localparam int scoreWidth = 16;
	localparam int livesWidth = 4;
	localparam int goodPoints = 10;
	localparam int badPoints = 5;
	localparam int bumperPoints = 1;
	localparam int startLives = 3;
	localparam int maxLives = 9;

	// High while the current pixel belongs to the layer.
	typedef struct packed {
		logic frame;
		logic flipper;
		logic obstacle;
		logic spring;
		logic bumper;
		logic bottom;
		logic credit;
		logic scoreCell; // Good half of the obstacle cells.
	} drawLayers;

	typedef struct packed {
		logic ballFrame;
		logic ballFlipper;
		logic flipperFrame;
		logic ballObstacle;
		logic obstacleGood;
		logic obstacleBad;
		logic ballSpring;
		logic ballBumper;
		logic ballBottom;
		logic ballCredit;
	} collisionFlags;

	typedef enum logic [1:0] {waitLaunch, playing, gameOver} gameState;
endpackage

`default_nettype wire

/* logic/scanGenerator.sv */
`default_nettype none
`timescale 1ns/1ps

module scanGenerator import videoPkg::*; #(
	parameter int screenWidth = 640,
	parameter int screenHeight = 480
) (
	input logic clk,
	input logic resetN,
	output screenPos pixel,
	output logic frameStart
);
	logic lastColumn;
	logic lastRow;

	assign lastColumn = pixel.column == coordWidth'(screenWidth - 1);
	assign lastRow = pixel.row == coordWidth'(screenHeight - 1);

	always_ff @(posedge clk or negedge resetN) begin
		if (!resetN) begin
			pixel <= '0;
		end else if (lastColumn) begin
			pixel.column <= '0;
			if (lastRow)
				pixel.row <= '0;
			else
				pixel.row <= pixel.row + 1'b1;
		end else begin
			pixel.column <= pixel.column + 1'b1;
		end
	end

	// One cycle per frame, at the top-left pixel.
	assign frameStart = pixel.column == '0 && pixel.row == '0;
endmodule

`default_nettype wire

/* logic/sceneRenderer.sv */
`default_nettype none
`timescale 1ns/1ps

module sceneRenderer import videoPkg::*, pinballPkg::*; #(
	parameter int screenWidth = 640,
	parameter int screenHeight = 480
) (
	input screenPos pixel,
	input logic flipperUp,
	output drawLayers layers
);
	localparam int floorRow = floorRowOf(screenHeight);
	localparam int gapLeft = screenWidth * 3 / 8;
	localparam int gapRight = screenWidth * 5 / 8; // First column past the gap.
	localparam int cellWidth = screenWidth / 8;
	localparam int obstacleLeft = screenWidth / 8;
	localparam int obstacleRight = screenWidth - screenWidth / 8;
	localparam int obstacleTop = screenHeight / 4;
	localparam int obstacleBottom = obstacleTop + screenHeight / 16;
	localparam int springLeft = springLeftOf(screenWidth);
	localparam int springTop = springTopOf(screenHeight);

	coord cellOffset;
	coord cellIndex;
	coord cellPhase;

	// True while the pixel lies in columns [left, right) and rows [top, bottom).
	function automatic logic inBox(screenPos p, int left, int right, int top, int bottom);
		return p.column >= left && p.column < right && p.row >= top && p.row < bottom;
	endfunction

	assign cellOffset = pixel.column - coordWidth'(obstacleLeft);
	assign cellIndex = cellOffset / coordWidth'(cellWidth);
	assign cellPhase = cellOffset % coordWidth'(cellWidth);

	always_comb begin
		layers.frame = pixel.row == 0
			|| (pixel.row <= floorRow && (pixel.column == 0 || pixel.column == screenWidth - 1))
			|| (pixel.row == floorRow && (pixel.column < gapLeft || pixel.column >= gapRight));
		// The flipper reaches one pixel into the floor on each side of the gap.
		layers.flipper = flipperUp
			&& inBox(pixel, gapLeft - 1, gapRight + 1, floorRow - 1, floorRow + 1);
		layers.obstacle = inBox(pixel, obstacleLeft, obstacleRight, obstacleTop, obstacleBottom)
			&& cellPhase < cellWidth - 2;
		layers.spring = inBox(pixel, springLeft, screenWidth - 1, springTop, floorRow);
		layers.bumper = inBox(pixel, screenWidth / 2 - screenWidth / 16,
			screenWidth / 2 + screenWidth / 16, screenHeight / 2 - screenHeight / 24,
			screenHeight / 2 + screenHeight / 24);
		layers.bottom = inBox(pixel, gapLeft, gapRight, floorRow + 4, screenHeight);
		layers.credit = inBox(pixel, screenWidth / 8, screenWidth / 8 + screenWidth / 16,
			screenHeight / 12, screenHeight / 12 + screenHeight / 24);
		layers.scoreCell = layers.obstacle && !cellIndex[0]; // Even cells score.
	end
endmodule

`default_nettype wire

/* logic/ballRenderer.sv */
`default_nettype none
`timescale 1ns/1ps

module ballRenderer import videoPkg::*, pinballPkg::*; #(
	parameter int screenWidth = 640,
	parameter int screenHeight = 480
) (
	input logic clk,
	input logic resetN,
	input screenPos pixel,
	input logic frameStart,
	input collisionFlags hits,
	input gameState state,
	input logic launch,
	output logic drawBall
);
	localparam int ballSize = 2;
	localparam int edgeMargin = 4;
	localparam int floorRow = floorRowOf(screenHeight);
	localparam screenPos parkPos = '{
		column: coordWidth'(springLeftOf(screenWidth) + 2),
		row: coordWidth'(springTopOf(screenHeight) - ballSize)
	};

	screenPos ball;
	logic dirRight;
	logic dirDown;
	logic moving;
	logic stickyFrame;
	logic stickyVert;
	logic stickyBottom;
	logic hitFrame;
	logic hitVert;
	logic hitBottom;
	logic nearSide;
	logic nearRowEdge;
	logic nextRight;
	logic nextDown;
	logic park;
	coord dx;
	coord dy;

	assign hitFrame = stickyFrame || hits.ballFrame;
	assign hitVert = stickyVert || hits.ballFlipper || hits.ballBumper || hits.ballObstacle;
	assign hitBottom = stickyBottom || hits.ballBottom;

	assign nearSide = ball.column < edgeMargin || ball.column > screenWidth - edgeMargin - ballSize;
	assign nearRowEdge = ball.row < edgeMargin || ball.row > floorRow - edgeMargin;

	always_comb begin
		nextRight = dirRight;
		nextDown = dirDown;
		if (hitVert)
			nextDown = !dirDown;
		// Frame bounces always head away from the wall that was hit.
		if (hitFrame && nearSide)
			nextRight = ball.column < screenWidth / 2;
		if (hitFrame && (nearRowEdge || !nearSide))
			nextDown = ball.row < screenHeight / 2;
	end

	assign park = state != playing || (frameStart && hitBottom);

	always_ff @(posedge clk or negedge resetN) begin
		if (!resetN) begin
			ball <= parkPos;
			dirRight <= 1'b0;
			dirDown <= 1'b0;
			moving <= 1'b0;
			stickyFrame <= 1'b0;
			stickyVert <= 1'b0;
			stickyBottom <= 1'b0;
		end else if (park) begin
			ball <= parkPos; // Up and left is the launch direction.
			dirRight <= 1'b0;
			dirDown <= 1'b0;
			moving <= 1'b0;
			stickyFrame <= 1'b0;
			stickyVert <= 1'b0;
			stickyBottom <= 1'b0;
		end else if (frameStart) begin
			stickyFrame <= 1'b0;
			stickyVert <= 1'b0;
			stickyBottom <= 1'b0;
			moving <= moving || launch;
			if (moving) begin
				ball.column <= nextRight ? ball.column + 1'b1 : ball.column - 1'b1;
				ball.row <= nextDown ? ball.row + 1'b1 : ball.row - 1'b1;
				dirRight <= nextRight;
				dirDown <= nextDown;
			end
		end else begin
			stickyFrame <= hitFrame;
			stickyVert <= hitVert;
			stickyBottom <= hitBottom;
			moving <= moving || launch;
		end
	end

	assign dx = pixel.column - ball.column;
	assign dy = pixel.row - ball.row;
	assign drawBall = dx < ballSize && dy < ballSize;
endmodule

`default_nettype wire

/* logic/collisionDetector.sv */
`default_nettype none
`timescale 1ns/1ps

module collisionDetector import pinballPkg::*; (
	input logic clk,
	input logic resetN,
	input logic frameStart,
	input logic drawBall,
	input drawLayers layers,
	output collisionFlags hits
);
	// Pairs tracked once per frame. Good and bad obstacle hits come from ballObstacle.
	typedef struct packed {
		logic ballFrame;
		logic ballFlipper;
		logic flipperFrame;
		logic ballObstacle;
		logic ballSpring;
		logic ballBumper;
		logic ballBottom;
		logic ballCredit;
	} pairSet;

	pairSet overlap;
	pairSet seen;
	pairSet seenThisFrame;
	pairSet first;

	assign overlap.ballFrame = drawBall && layers.frame;
	assign overlap.ballFlipper = drawBall && layers.flipper;
	assign overlap.flipperFrame = layers.flipper && layers.frame; // No ball involved.
	assign overlap.ballObstacle = drawBall && layers.obstacle;
	assign overlap.ballSpring = drawBall && layers.spring;
	assign overlap.ballBumper = drawBall && layers.bumper;
	assign overlap.ballBottom = drawBall && layers.bottom;
	assign overlap.ballCredit = drawBall && layers.credit;

	// The frameStart pixel already belongs to the new frame.
	assign seenThisFrame = frameStart ? pairSet'('0) : seen;
	assign first = overlap & ~seenThisFrame;

	always_ff @(posedge clk or negedge resetN) begin
		if (!resetN) begin
			seen <= '0;
		end else begin
			seen <= seenThisFrame | overlap; // A set wins over the frame clear.
		end
	end

	assign hits.ballFrame = first.ballFrame;
	assign hits.ballFlipper = first.ballFlipper;
	assign hits.flipperFrame = first.flipperFrame;
	assign hits.ballObstacle = first.ballObstacle;
	assign hits.obstacleGood = first.ballObstacle && layers.scoreCell;
	assign hits.obstacleBad = first.ballObstacle && !layers.scoreCell;
	assign hits.ballSpring = first.ballSpring;
	assign hits.ballBumper = first.ballBumper;
	assign hits.ballBottom = first.ballBottom;
	assign hits.ballCredit = first.ballCredit;
endmodule

`default_nettype wire

/* logic/scoreKeeper.sv */
`default_nettype none
`timescale 1ns/1ps

module scoreKeeper import pinballPkg::*; (
	input logic clk,
	input logic resetN,
	input collisionFlags hits,
	input logic launch,
	output logic [scoreWidth-1:0] score,
	output logic [livesWidth-1:0] lives,
	output gameState state
);
	logic [scoreWidth:0] raised;
	logic [scoreWidth-1:0] scoreNext;

	always_comb begin
		raised = {1'b0, score};
		if (hits.obstacleGood)
			raised = raised + (scoreWidth + 1)'(goodPoints);
		if (hits.ballBumper)
			raised = raised + (scoreWidth + 1)'(bumperPoints);
		if (raised[scoreWidth])
			scoreNext = '1; // Hold at the top instead of wrapping.
		else if (hits.obstacleBad && raised[scoreWidth-1:0] < badPoints)
			scoreNext = '0;
		else if (hits.obstacleBad)
			scoreNext = raised[scoreWidth-1:0] - scoreWidth'(badPoints);
		else
			scoreNext = raised[scoreWidth-1:0];
	end

	always_ff @(posedge clk or negedge resetN) begin
		if (!resetN) begin
			state <= waitLaunch;
			score <= '0;
			lives <= livesWidth'(startLives);
		end else begin
			case (state)
				waitLaunch: if (launch) state <= playing;
				playing: begin
					score <= scoreNext;
					if (hits.ballBottom) begin
						lives <= lives - 1'b1;
						state <= lives == livesWidth'(1) ? gameOver : waitLaunch;
					end else if (hits.ballCredit && lives < maxLives) begin
						lives <= lives + 1'b1;
					end
				end
				gameOver: if (launch) begin
					score <= '0;
					lives <= livesWidth'(startLives);
					state <= waitLaunch;
				end
				default: state <= waitLaunch;
			endcase
		end
	end
endmodule

`default_nettype wire

/* logic/pinballTop.sv */
`default_nettype none
`timescale 1ns/1ps

module pinballTop import videoPkg::*, pinballPkg::*; #(
	parameter int screenWidth = 640,
	parameter int screenHeight = 480
) (
	input logic clk,
	input logic resetN,
	input logic launch,
	input logic flipperUp,
	output logic frameStart,
	output drawLayers layers,
	output logic drawBall,
	output collisionFlags collisions,
	output logic [scoreWidth-1:0] score,
	output logic [livesWidth-1:0] lives,
	output gameState state
);
	screenPos pixel;

	scanGenerator #(.screenWidth(screenWidth), .screenHeight(screenHeight)) scan (
		.clk(clk),
		.resetN(resetN),
		.pixel(pixel),
		.frameStart(frameStart)
	);

	sceneRenderer #(.screenWidth(screenWidth), .screenHeight(screenHeight)) scene (
		.pixel(pixel),
		.flipperUp(flipperUp),
		.layers(layers)
	);

	ballRenderer #(.screenWidth(screenWidth), .screenHeight(screenHeight)) ball (
		.clk(clk),
		.resetN(resetN),
		.pixel(pixel),
		.frameStart(frameStart),
		.hits(collisions),
		.state(state),
		.launch(launch),
		.drawBall(drawBall)
	);

	collisionDetector detector (
		.clk(clk),
		.resetN(resetN),
		.frameStart(frameStart),
		.drawBall(drawBall),
		.layers(layers),
		.hits(collisions)
	);

	scoreKeeper keeper (
		.clk(clk),
		.resetN(resetN),
		.hits(collisions),
		.launch(launch),
		.score(score),
		.lives(lives),
		.state(state)
	);
endmodule

`default_nettype wire

/* verif/pinballTb.sv */
`default_nettype none
`timescale 1ns/1ps

module pinballTb import pinballPkg::*; ();
	localparam int screenWidth = 64;
	localparam int screenHeight = 48;
	localparam int frameCycles = screenWidth * screenHeight;
	localparam int clockPeriod = 40;
	localparam int resetCycles = 16;
	localparam int printLimit = 20;
	// Frame budgets of the tests, in test order.
	localparam int playFrames = 40;
	localparam int splitFrames = 80;
	localparam int scoreFrames = 80;
	localparam int loseFrames = 120;
	localparam int gapFrames = 30;
	localparam int watchdogFrames = 2 + playFrames + splitFrames + scoreFrames + loseFrames
		+ gapFrames;

	logic clk = 1'b0;
	logic resetN;
	logic launch;
	logic flipperUp;
	logic frameStart;
	drawLayers layers;
	logic drawBall;
	collisionFlags collisions;
	logic [scoreWidth-1:0] score;
	logic [livesWidth-1:0] lives;
	gameState state;

	int errors = 0;
	int testsRun = 0;
	int testsFailed = 0;
	logic [31:0] lfsr = 32'hf4b7;
	int modelScore;
	logic [livesWidth-1:0] modelLives;
	gameState modelState;
	collisionFlags raw;
	collisionFlags seen;
	collisionFlags expected;
	int pixelIndex = 0;
	logic frameOpened = 1'b0;
	int frameFlipPulses = 0;
	int frameFlipPixels = 0;
	int lastFlipPulses = 0;
	int lastFlipPixels = 0;
	int ballPulses = 0;
	int obstaclePulses = 0;
	int scorePulses = 0;
	int bottomPulses = 0;

	always #(clockPeriod / 2) clk = ~clk;

	pinballTop #(.screenWidth(screenWidth), .screenHeight(screenHeight)) dut (
		.clk(clk),
		.resetN(resetN),
		.launch(launch),
		.flipperUp(flipperUp),
		.frameStart(frameStart),
		.layers(layers),
		.drawBall(drawBall),
		.collisions(collisions),
		.score(score),
		.lives(lives),
		.state(state)
	);

	function automatic logic nextRandomBit();
		logic out;
		out = lfsr[0];
		lfsr = lfsr >> 1;
		if (out)
			lfsr = lfsr ^ 32'hA3000000; // Maximal length taps.
		return out;
	endfunction

	task automatic checkCollisions(input collisionFlags want, input collisionFlags got);
		if (got !== want) begin
			errors++;
			if (errors <= printLimit)
				$display("MISMATCH at %0t: collisions expected %b, got %b", $time, want, got);
		end
	endtask

	task automatic checkState(input gameState want, input gameState got);
		if (got !== want) begin
			errors++;
			if (errors <= printLimit)
				$display("MISMATCH at %0t: state expected %s, got %s", $time, want.name(),
					got.name());
		end
	endtask

	task automatic checkCount(input string name, input logic [scoreWidth-1:0] want,
		input logic [scoreWidth-1:0] got);
		if (got !== want) begin
			errors++;
			if (errors <= printLimit)
				$display("MISMATCH at %0t: %s expected %0d, got %0d", $time, name, want, got);
		end
	endtask

	task automatic requireSeen(input logic seenIt, input string what);
		if (!seenIt) begin
			errors++;
			$display("%s was never seen", what);
		end
	endtask

	task automatic finishTest(input string name, input int startErrors, input string note);
		testsRun++;
		if (errors == startErrors) begin
			$display("%s: ok, %s", name, note);
		end else begin
			testsFailed++;
			$display("%s: failed with %0d errors, %s", name, errors - startErrors, note);
		end
	endtask

	task automatic nextDrivePoint();
		@(posedge clk);
		#2;
	endtask

	task automatic waitFrames(input int count);
		repeat (count) begin
			@(negedge clk);
			while (!frameStart)
				@(negedge clk);
		end
	endtask

	task automatic pressLaunch(input int cycles);
		nextDrivePoint();
		launch = 1'b1;
		repeat (cycles)
			nextDrivePoint();
		launch = 1'b0;
	endtask

	// Reference checks on every cycle, sampled at the falling edge where all outputs are settled.
	always @(negedge clk) begin
		if (!resetN) begin
			modelScore = 0;
			modelLives = livesWidth'(startLives);
			modelState = waitLaunch;
			seen = '0;
			pixelIndex = 0;
			frameOpened = 1'b0;
		end else begin
			checkCount("score", scoreWidth'(modelScore), score);
			checkCount("lives", scoreWidth'(modelLives), scoreWidth'(lives));
			checkState(modelState, state);
			if (!frameOpened && !frameStart) begin
				errors++;
				$display("frameStart was low in the first cycle after reset at %0t", $time);
			end
			if (frameStart) begin
				// Frames are exactly one screen of pixels apart.
				if (frameOpened && pixelIndex != frameCycles - 1) begin
					errors++;
					$display("frameStart came after %0d cycles instead of %0d at %0t",
						pixelIndex + 1, frameCycles, $time);
				end
				frameOpened = 1'b1;
				seen = '0; // The first pixel opens a new frame.
				pixelIndex = 0;
				lastFlipPulses = frameFlipPulses;
				lastFlipPixels = frameFlipPixels;
				frameFlipPulses = 0;
				frameFlipPixels = 0;
			end else begin
				pixelIndex++;
			end
			raw = '0;
			raw.ballFrame = drawBall && layers.frame;
			raw.ballFlipper = drawBall && layers.flipper;
			raw.flipperFrame = layers.flipper && layers.frame;
			raw.ballObstacle = drawBall && layers.obstacle;
			raw.ballSpring = drawBall && layers.spring;
			raw.ballBumper = drawBall && layers.bumper;
			raw.ballBottom = drawBall && layers.bottom;
			raw.ballCredit = drawBall && layers.credit;
			expected = raw & ~seen;
			expected.obstacleGood = expected.ballObstacle && layers.scoreCell;
			expected.obstacleBad = expected.ballObstacle && !layers.scoreCell;
			seen = seen | raw;
			checkCollisions(expected, collisions);
			if (collisions.ballFrame || collisions.ballObstacle || collisions.ballSpring
				|| collisions.ballBumper || collisions.ballFlipper)
				ballPulses++;
			if (collisions.ballObstacle)
				obstaclePulses++;
			if (collisions.ballBottom)
				bottomPulses++;
			if (collisions.flipperFrame)
				frameFlipPulses++;
			if (layers.flipper) begin
				frameFlipPixels++;
				if (pixelIndex / screenWidth < screenHeight * 3 / 4
					|| pixelIndex % screenWidth < screenWidth / 4
					|| pixelIndex % screenWidth >= screenWidth * 3 / 4) begin
					errors++;
					$display("flipper drawn outside the bottom gap at %0t", $time);
				end
			end
			case (modelState)
				waitLaunch: if (launch) modelState = playing;
				playing: begin
					if (collisions.obstacleGood || collisions.obstacleBad || collisions.ballBumper
						|| collisions.ballCredit || collisions.ballBottom)
						scorePulses++;
					if (collisions.obstacleGood)
						modelScore += goodPoints;
					if (collisions.ballBumper)
						modelScore += bumperPoints;
					if (collisions.obstacleBad)
						modelScore = modelScore < badPoints ? 0 : modelScore - badPoints;
					if (collisions.ballBottom) begin
						modelState = modelLives == 1 ? gameOver : waitLaunch;
						modelLives = modelLives - 1'b1;
					end else if (collisions.ballCredit && modelLives < maxLives) begin
						modelLives = modelLives + 1'b1;
					end
				end
				gameOver: if (launch) begin
					modelScore = 0;
					modelLives = livesWidth'(startLives);
					modelState = waitLaunch;
				end
				default: modelState = waitLaunch;
			endcase
		end
	end

	task automatic resetState();
		int startErrors;
		startErrors = errors;
		repeat (resetCycles) begin
			@(negedge clk);
			checkCollisions('0, collisions);
			checkCount("score", '0, score);
			checkCount("lives", scoreWidth'(startLives), scoreWidth'(lives));
			checkState(waitLaunch, state);
		end
		nextDrivePoint();
		resetN = 1'b1;
		@(negedge clk);
		checkCount("score", '0, score);
		checkCount("lives", scoreWidth'(startLives), scoreWidth'(lives));
		checkState(waitLaunch, state);
		finishTest("resetState", startErrors, "held for 16 cycles");
	endtask

	task automatic oncePerFrame();
		int startErrors;
		int startPulses;
		startErrors = errors;
		startPulses = ballPulses;
		pressLaunch(3);
		waitFrames(playFrames);
		requireSeen(ballPulses > startPulses, "a ball collision pulse");
		finishTest("oncePerFrame", startErrors,
			$sformatf("%0d ball pulses", ballPulses - startPulses));
	endtask

	task automatic obstacleSplit();
		int startErrors;
		int startPulses;
		startErrors = errors;
		startPulses = obstaclePulses;
		waitFrames(splitFrames);
		requireSeen(obstaclePulses > startPulses, "an obstacle pulse");
		finishTest("obstacleSplit", startErrors,
			$sformatf("%0d obstacle pulses", obstaclePulses - startPulses));
	endtask

	task automatic scoring();
		int startErrors;
		int startPulses;
		startErrors = errors;
		startPulses = scorePulses;
		waitFrames(scoreFrames);
		requireSeen(scorePulses > startPulses, "a scoring pulse");
		finishTest("scoring", startErrors, $sformatf("score %0d, lives %0d", score, lives));
	endtask

	task automatic loseLives();
		int startErrors;
		int startFalls;
		int frames;
		startErrors = errors;
		startFalls = bottomPulses;
		flipperUp = 1'b0;
		for (frames = 0; frames < loseFrames && state != gameOver; frames++) begin
			waitFrames(1);
			if (state == waitLaunch)
				pressLaunch(3);
		end
		if (state == gameOver) begin
			pressLaunch(1);
			@(negedge clk);
			checkCount("score", '0, score);
			checkCount("lives", scoreWidth'(startLives), scoreWidth'(lives));
			checkState(waitLaunch, state);
		end
		finishTest("loseLives", startErrors,
			$sformatf("%0d falls, lives %0d", bottomPulses - startFalls, lives));
	endtask

	task automatic flipperGap();
		int startErrors;
		int hold;
		int i;
		int f;
		startErrors = errors;
		waitFrames(1);
		nextDrivePoint();
		for (i = 0; i < 6; i++) begin
			hold = 1 + 2 * int'(nextRandomBit()) + int'(nextRandomBit());
			flipperUp = i % 2 == 0;
			for (f = 0; f < hold; f++) begin
				waitFrames(1);
				nextDrivePoint();
				checkCount("flipperFrame pulses per frame", scoreWidth'(flipperUp),
					scoreWidth'(lastFlipPulses));
				if ((lastFlipPixels > 0) != flipperUp) begin
					errors++;
					$display("flipper layer was %0d pixels with flipperUp %b", lastFlipPixels,
						flipperUp);
				end
			end
		end
		flipperUp = 1'b0;
		finishTest("flipperGap", startErrors, "six flipper holds");
	endtask

	initial begin
		#(watchdogFrames * frameCycles * clockPeriod);
		$display("watchdog expired after %0d frames before the tests finished", watchdogFrames);
		$display("tests failed");
		$finish;
	end

	initial begin
		resetN = 1'b0;
		launch = 1'b0;
		flipperUp = 1'b0;
		resetState();
		oncePerFrame();
		obstacleSplit();
		scoring();
		loseLives();
		flipperGap();
		$display("%0d tests, %0d failed, %0d errors", testsRun, testsFailed, errors);
		if (errors == 0)
			$display("all tests passed");
		else
			$display("tests failed");
		$finish;
	end
endmodule

`default_nettype wire

/* files.f */
logic/videoPkg.sv
logic/pinballPkg.sv
logic/scanGenerator.sv
logic/sceneRenderer.sv
logic/ballRenderer.sv
logic/collisionDetector.sv
logic/scoreKeeper.sv
logic/pinballTop.sv
verif/pinballTb.sv

/* run.sh */
#!/bin/sh
# Builds the pinball testbench with Verilator and runs it.
cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing -Wno-fatal -f files.f --top-module pinballTb; then
	echo "Verilator build failed"
	exit 1
fi

output=$(./obj_dir/VpinballTb)
status=$?
echo "$output"
if [ "$status" -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if echo "$output" | grep -qx "all tests passed"; then
	exit 0
fi
exit 1
